// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP       = conv_tile_tb
FILELIST  = verilog.f
LOG       = sim.log
FAIL_MSG  = test failed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/conv_tile_chk.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the tile top level
module conv_tile_chk (
    input logic clk,
    input logic rst,
    input logic fm_we,
    input logic wt_we,
    input logic load_done,
    input logic compute,
    input logic result_valid
);

    ////////////////////////////////////////
    // Loader
    ////////////////////////////////////////

    a_we_after_reset: assert property (@(posedge clk) rst |=> (!fm_we && !wt_we))
        else $error("write enable active in the cycle after reset");

    // Single-cycle done strobe
    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
                                   load_done |=> !load_done)
        else $error("load_done high on two consecutive cycles");

    ////////////////////////////////////////
    // MAC
    ////////////////////////////////////////

    a_mac_latency: assert property (@(posedge clk) disable iff (rst)
                                    compute |-> ##3 result_valid)
        else $error("result_valid missing three cycles after compute");

endmodule

bind conv_tile_top conv_tile_chk u_chk (
    .clk          (clk),
    .rst          (rst),
    .fm_we        (fm_we),
    .wt_we        (wt_we),
    .load_done    (load_done),
    .compute      (compute),
    .result_valid (result_valid)
);

`default_nettype wire

// File: bench/conv_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_tile_tb;

    localparam int N_WIN       = `CNN_FM_DEPTH;
    localparam int N_KER       = `CNN_WT_DEPTH;
    localparam int N_EL        = `CNN_KERNEL_ELEMS;
    localparam int FILL_CYCLES = 36;   // init to load_done
    localparam int MAC_LATENCY = 3;

    logic              clk;
    logic              rst;
    logic              init;
    cnn_pkg::elem_t    fm_fill;
    cnn_pkg::elem_t    wt_fill;
    logic              update;
    cnn_pkg::wt_addr_t update_addr;
    cnn_pkg::elem_t    update_value;
    logic              load_done;
    logic              compute;
    cnn_pkg::fm_addr_t fm_addr;
    cnn_pkg::wt_addr_t wt_addr;
    logic              result_valid;
    cnn_pkg::acc_t     result;

    // Expected buffer contents
    cnn_pkg::elem_t fm_model [N_WIN][N_EL];
    cnn_pkg::elem_t coef_model [N_KER][N_EL];
    cnn_pkg::elem_t bias_model [N_KER];

    // Computes in flight with the oldest first
    logic signed [63:0] exp_q [$];
    int                 issue_q [$];
    string              name_q [$];

    int          cyc;
    logic [31:0] rng;
    string       test_name;

    conv_tile_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .init         (init),
        .fm_fill      (fm_fill),
        .wt_fill      (wt_fill),
        .update       (update),
        .update_addr  (update_addr),
        .update_value (update_value),
        .load_done    (load_done),
        .compute      (compute),
        .fm_addr      (fm_addr),
        .wt_addr      (wt_addr),
        .result_valid (result_valid),
        .result       (result)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // Signed dot product of window a and kernel k plus bias
    function automatic logic signed [63:0] expected_result(input int a, input int k);
        longint sum;
        sum = longint'(bias_model[k]);
        for (int i = 0; i < N_EL; i++) begin
            sum += longint'(fm_model[a][i]) * longint'(coef_model[k][i]);
        end
        return sum;
    endfunction

    task automatic model_fill(input cnn_pkg::elem_t fm, input cnn_pkg::elem_t wt);
        for (int a = 0; a < N_WIN; a++) begin
            for (int i = 0; i < N_EL; i++) begin
                fm_model[a][i] = cnn_pkg::elem_t'(fm + 9 * a + i);   // Wraps at 16 bits
            end
        end
        for (int k = 0; k < N_KER; k++) begin
            for (int i = 0; i < N_EL; i++) begin
                coef_model[k][i] = cnn_pkg::elem_t'(wt + 9 * k + i);
            end
            bias_model[k] = cnn_pkg::elem_t'(wt + k);
        end
    endtask

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic signed [63:0] expected,
                               input logic signed [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            fail_run("compared value differs from the model");
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;   // Drive and sample just after the edge
    endtask

    task automatic pulse_init(input cnn_pkg::elem_t fm, input cnn_pkg::elem_t wt);
        init    = 1'b1;
        fm_fill = fm;
        wt_fill = wt;
        step();
        init    = 1'b0;
    endtask

    task automatic pulse_update(input int k, input cnn_pkg::elem_t v);
        update       = 1'b1;
        update_addr  = cnn_pkg::wt_addr_t'(k);
        update_value = v;
        step();
        update       = 1'b0;
    endtask

    task automatic issue_compute(input int a, input int k);
        compute = 1'b1;
        fm_addr = cnn_pkg::fm_addr_t'(a);
        wt_addr = cnn_pkg::wt_addr_t'(k);
        exp_q.push_back(expected_result(a, k));
        issue_q.push_back(cyc);
        name_q.push_back($sformatf("%s w%0d k%0d", test_name, a, k));
        step();
        compute = 1'b0;
    endtask

    // Counts cycles from the init strobe until load_done
    task automatic wait_load_done(input int start, output int total);
        total = start;
        do begin
            if (total > FILL_CYCLES + 20) fail_run("load_done never arrived after init");
            step();
            total++;
        end while (!load_done);
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0) begin
            if (n > MAC_LATENCY + 5) fail_run("result_valid missing for an issued compute");
            step();
            n++;
        end
    endtask

    ////////////////////////////////////////
    // Result compare
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (!rst && result_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("result_valid pulsed with no compute outstanding");
            end else begin
                check_equal({name_q[0], " latency"}, MAC_LATENCY, cyc - issue_q[0]);
                check_equal(name_q[0], exp_q[0], result);
                void'(exp_q.pop_front());
                void'(issue_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    // Hard limit on run length
    initial begin
        repeat (5000) @(posedge clk);
        fail_run("simulation ran past its cycle limit");
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial begin
        int          n;
        int          k;
        logic [31:0] r;
        clk          = 1'b0;
        rst          = 1'b1;
        init         = 1'b0;
        fm_fill      = '0;
        wt_fill      = '0;
        update       = 1'b0;
        update_addr  = '0;
        update_value = '0;
        compute      = 1'b0;
        fm_addr      = '0;
        wt_addr      = '0;
        cyc          = 0;
        rng          = 32'he1347558;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_name = "reset";
        repeat (4) begin
            step();
            check_equal("load_done idle", 0, load_done);
            check_equal("result_valid idle", 0, result_valid);
        end

        test_name = "first fill";
        r = next_rand();
        pulse_init(r[15:0], r[31:16]);
        model_fill(r[15:0], r[31:16]);
        wait_load_done(1, n);
        check_equal("fill latency", FILL_CYCLES, n);

        test_name = "kernel 0 sweep";
        for (int a = 0; a < N_WIN; a++) issue_compute(a, 0);
        wait_drained();

        test_name = "random stream";   // One compute per cycle
        repeat (40) begin
            r = next_rand();
            issue_compute(int'(r[15:0]) % N_WIN, int'(r[17:16]));
        end
        wait_drained();

        test_name = "kernel update";
        r = next_rand();
        k = int'(r[1:0]);
        pulse_update(k, r[31:16]);
        for (int i = 0; i < N_EL; i++) coef_model[k][i] = r[31:16];
        bias_model[k] = '0;
        step();   // Kernel word is in memory now
        for (int a = 0; a < N_WIN; a++) issue_compute(a, k);
        repeat (8) begin
            r = next_rand();
            issue_compute(int'(r[15:0]) % N_WIN, int'(r[17:16]));
        end
        wait_drained();

        // Second init and an update land mid-fill and must be dropped
        test_name = "strobes during fill";
        r = next_rand();
        pulse_init(r[15:0], r[31:16]);
        model_fill(r[15:0], r[31:16]);
        n = 1;
        repeat (9) begin
            step();
            n++;
        end
        r = next_rand();
        pulse_init(r[15:0], r[31:16]);
        n++;
        repeat (9) begin
            step();
            n++;
        end
        k = int'(r[1:0]);
        pulse_update(k, r[31:16]);
        n++;
        wait_load_done(n, n);
        check_equal("fill latency", FILL_CYCLES, n);
        for (int a = 0; a < N_WIN; a++) issue_compute(a, k);   // Kernel the update named
        repeat (24) begin
            r = next_rand();
            issue_compute(int'(r[15:0]) % N_WIN, int'(r[17:16]));
        end
        wait_drained();

        test_name = "refill";
        r = next_rand();
        pulse_init(r[15:0], r[31:16]);
        model_fill(r[15:0], r[31:16]);
        wait_load_done(1, n);
        check_equal("fill latency", FILL_CYCLES, n);
        for (int kk = 0; kk < N_KER; kk++) begin
            for (int a = 0; a < N_WIN; a++) issue_compute(a, kk);
        end
        wait_drained();

        repeat (5) step();
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////

// Signed fixed-point element
`define CNN_DATA_WIDTH   16

// 3x3 window or kernel, flattened
`define CNN_KERNEL_ELEMS 9

////////////////////////////////////////
// Buffer depths
////////////////////////////////////////

`define CNN_FM_DEPTH     18   // Windows in the feature-map buffer
`define CNN_WT_DEPTH     4    // Kernels in the weight buffer

////////////////////////////////////////
// Accumulator
////////////////////////////////////////

// Nine 32-bit products plus bias need 36 bits, rounded up
`define CNN_ACC_WIDTH    40

`endif

// File: hw/cnn_pkg.sv
`default_nettype none

`include "cnn_cfg.svh"

package cnn_pkg;

    ////////////////////////////////////////
    // Payload types
    ////////////////////////////////////////

    // One signed element
    typedef logic signed [`CNN_DATA_WIDTH-1:0] elem_t;

    // One window, element 0 in the low bits
    typedef elem_t [`CNN_KERNEL_ELEMS-1:0] fm_word_t;

    // One kernel plus its bias
    typedef struct packed {
        elem_t [`CNN_KERNEL_ELEMS-1:0] coef;
        elem_t                         bias;
    } wt_word_t;

    ////////////////////////////////////////
    // Addresses and results
    ////////////////////////////////////////

    typedef logic [$clog2(`CNN_FM_DEPTH)-1:0] fm_addr_t;   // 5 bits
    typedef logic [$clog2(`CNN_WT_DEPTH)-1:0] wt_addr_t;   // 2 bits

    // MAC output, sign-extended dot product plus bias
    typedef logic signed [`CNN_ACC_WIDTH-1:0] acc_t;

endpackage

`default_nettype wire

// File: hw/conv_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_cfg.svh"

// Window times kernel plus bias, three cycles from compute to result
module conv_mac (
    input  logic              clk,
    input  logic              rst,
    input  logic              compute,
    input  cnn_pkg::fm_word_t fm_rdata,
    input  cnn_pkg::wt_word_t wt_rdata,
    output logic              result_valid,
    output cnn_pkg::acc_t     result
);

    localparam int PROD_W = 2 * `CNN_DATA_WIDTH;

    logic                     rd_valid;    // Buffer data valid this cycle
    logic                     prod_valid;
    logic signed [PROD_W-1:0] prod_q [`CNN_KERNEL_ELEMS];
    cnn_pkg::elem_t           bias_q;
    cnn_pkg::acc_t            lvl1 [5];
    cnn_pkg::acc_t            lvl2 [2];
    cnn_pkg::acc_t            lvl3;
    cnn_pkg::acc_t            sum_all;

    ////////////////////////////////////////
    // Valid pipeline
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid     <= 1'b0;
            prod_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            rd_valid     <= compute;     // Lines up with registered read
            prod_valid   <= rd_valid;
            result_valid <= prod_valid;
        end
    end

    ////////////////////////////////////////
    // Stage 1, multipliers
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rd_valid) begin
            for (int i = 0; i < `CNN_KERNEL_ELEMS; i++) begin
                prod_q[i] <= fm_rdata[i] * wt_rdata.coef[i];   // 16x16 signed
            end
            bias_q <= wt_rdata.bias;
        end
    end

    ////////////////////////////////////////
    // Stage 2, adder tree with bias
    ////////////////////////////////////////

    always_comb begin
        // Pairs, bias rides with the odd product
        for (int j = 0; j < 4; j++) begin
            lvl1[j] = cnn_pkg::acc_t'(prod_q[2*j]) + cnn_pkg::acc_t'(prod_q[2*j+1]);
        end
        lvl1[4] = cnn_pkg::acc_t'(prod_q[8]) + cnn_pkg::acc_t'(bias_q);

        lvl2[0] = lvl1[0] + lvl1[1];
        lvl2[1] = lvl1[2] + lvl1[3];

        lvl3    = lvl2[0] + lvl2[1];
        sum_all = lvl3 + lvl1[4];
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            result <= sum_all;
        end
    end

endmodule

`default_nettype wire

// File: hw/conv_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_cfg.svh"

module conv_tile_top (
    input  logic              clk,
    input  logic              rst,

    // Buffer fill and kernel rewrite
    input  logic              init,
    input  cnn_pkg::elem_t    fm_fill,
    input  cnn_pkg::elem_t    wt_fill,
    input  logic              update,
    input  cnn_pkg::wt_addr_t update_addr,
    input  cnn_pkg::elem_t    update_value,
    output logic              load_done,

    // Compute request and result
    input  logic              compute,
    input  cnn_pkg::fm_addr_t fm_addr,
    input  cnn_pkg::wt_addr_t wt_addr,
    output logic              result_valid,
    output cnn_pkg::acc_t     result
);

    logic              fm_we;
    cnn_pkg::fm_addr_t fm_waddr;
    cnn_pkg::fm_word_t fm_wdata;
    cnn_pkg::fm_word_t fm_rdata;
    logic              wt_we;
    cnn_pkg::wt_addr_t wt_waddr;
    cnn_pkg::wt_word_t wt_wdata;
    cnn_pkg::wt_word_t wt_rdata;

    data_loader u_loader (
        .clk          (clk),
        .rst          (rst),
        .init         (init),
        .fm_fill      (fm_fill),
        .wt_fill      (wt_fill),
        .update       (update),
        .update_addr  (update_addr),
        .update_value (update_value),
        .fm_we        (fm_we),
        .fm_waddr     (fm_waddr),
        .fm_wdata     (fm_wdata),
        .wt_we        (wt_we),
        .wt_waddr     (wt_waddr),
        .wt_wdata     (wt_wdata),
        .load_done    (load_done)
    );

    ////////////////////////////////////////
    // Buffers, read side driven by compute addresses
    ////////////////////////////////////////

    tile_buffer #(
        .payload_t (cnn_pkg::fm_word_t),
        .DEPTH     (`CNN_FM_DEPTH)
    ) u_fm_buf (
        .clk   (clk),
        .we    (fm_we),
        .waddr (fm_waddr),
        .wdata (fm_wdata),
        .raddr (fm_addr),
        .rdata (fm_rdata)
    );

    tile_buffer #(
        .payload_t (cnn_pkg::wt_word_t),
        .DEPTH     (`CNN_WT_DEPTH)
    ) u_wt_buf (
        .clk   (clk),
        .we    (wt_we),
        .waddr (wt_waddr),
        .wdata (wt_wdata),
        .raddr (wt_addr),
        .rdata (wt_rdata)
    );

    conv_mac u_mac (
        .clk          (clk),
        .rst          (rst),
        .compute      (compute),
        .fm_rdata     (fm_rdata),
        .wt_rdata     (wt_rdata),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: hw/data_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cnn_cfg.svh"

module data_loader (
    input  logic              clk,
    input  logic              rst,
    input  logic              init,
    input  cnn_pkg::elem_t    fm_fill,
    input  cnn_pkg::elem_t    wt_fill,
    input  logic              update,
    input  cnn_pkg::wt_addr_t update_addr,
    input  cnn_pkg::elem_t    update_value,
    output logic              fm_we,
    output cnn_pkg::fm_addr_t fm_waddr,
    output cnn_pkg::fm_word_t fm_wdata,
    output logic              wt_we,
    output cnn_pkg::wt_addr_t wt_waddr,
    output cnn_pkg::wt_word_t wt_wdata,
    output logic              load_done
);

    // Window whose elements count up from base
    function automatic cnn_pkg::fm_word_t make_window(input cnn_pkg::elem_t base);
        cnn_pkg::fm_word_t w;
        for (int i = 0; i < `CNN_KERNEL_ELEMS; i++) begin
            w[i] = cnn_pkg::elem_t'(base + i);
        end
        return w;
    endfunction

    // Kernel with counting coefficients and the given bias
    function automatic cnn_pkg::wt_word_t make_kernel(input cnn_pkg::elem_t base,
                                                      input cnn_pkg::elem_t bias);
        cnn_pkg::wt_word_t k;
        for (int i = 0; i < `CNN_KERNEL_ELEMS; i++) begin
            k.coef[i] = cnn_pkg::elem_t'(base + i);
        end
        k.bias = bias;
        return k;
    endfunction

    logic                                 busy;
    logic                                 phase;     // High in the gap cycle
    logic [$clog2(`CNN_FM_DEPTH+1)-1:0]  fm_cnt;    // Next window to write
    logic [$clog2(`CNN_WT_DEPTH+1)-1:0]  wt_cnt;    // Next kernel to write
    cnn_pkg::elem_t                       fm_fill_q;
    cnn_pkg::elem_t                       wt_fill_q;
    cnn_pkg::elem_t                       fm_base;
    cnn_pkg::elem_t                       wt_base;
    cnn_pkg::elem_t                       wt_bias;
    cnn_pkg::wt_word_t                    upd_word;
    logic                                 start_fill;
    logic                                 take_update;
    logic                                 step;

    assign start_fill  = !busy && init;
    assign take_update = !busy && !init && update;   // Init wins a tie
    assign step        = busy && !phase;             // Write slot

    // Fill rule applied to the current counters
    assign fm_base = cnn_pkg::elem_t'(fm_fill_q + 9 * fm_cnt);
    assign wt_base = cnn_pkg::elem_t'(wt_fill_q + 9 * wt_cnt);
    assign wt_bias = cnn_pkg::elem_t'(wt_fill_q + wt_cnt);

    always_comb begin
        upd_word.coef = {`CNN_KERNEL_ELEMS{update_value}};
        upd_word.bias = '0;
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            phase     <= 1'b0;
            fm_cnt    <= '0;
            wt_cnt    <= '0;
            fm_we     <= 1'b0;
            wt_we     <= 1'b0;
            load_done <= 1'b0;
        end else begin
            fm_we     <= 1'b0;
            wt_we     <= 1'b0;
            load_done <= 1'b0;
            if (start_fill) begin
                busy   <= 1'b1;
                phase  <= 1'b1;
                fm_cnt <= 1;
                wt_cnt <= 1;
                fm_we  <= 1'b1;   // Word 0 of both buffers
                wt_we  <= 1'b1;
            end else if (take_update) begin
                wt_we <= 1'b1;
            end else if (busy) begin
                phase <= ~phase;
                if (step) begin
                    fm_we  <= 1'b1;
                    fm_cnt <= fm_cnt + 1'b1;
                    if (wt_cnt < `CNN_WT_DEPTH) begin
                        wt_we  <= 1'b1;
                        wt_cnt <= wt_cnt + 1'b1;
                    end
                end else if (fm_cnt == `CNN_FM_DEPTH) begin
                    busy      <= 1'b0;   // Last window went out last cycle
                    load_done <= 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Write address and data
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fm_fill_q <= fm_fill;
            wt_fill_q <= wt_fill;
            fm_waddr  <= '0;
            fm_wdata  <= make_window(fm_fill);
            wt_waddr  <= '0;
            wt_wdata  <= make_kernel(wt_fill, wt_fill);
        end else if (take_update) begin
            wt_waddr <= update_addr;
            wt_wdata <= upd_word;
        end else if (step) begin
            fm_waddr <= cnn_pkg::fm_addr_t'(fm_cnt);
            fm_wdata <= make_window(fm_base);
            wt_waddr <= cnn_pkg::wt_addr_t'(wt_cnt);
            wt_wdata <= make_kernel(wt_base, wt_bias);
        end
    end

endmodule

`default_nettype wire

// File: hw/tile_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// Simple dual-port memory, one write port and one registered read port
module tile_buffer #(
    parameter type payload_t = logic [15:0],
    parameter int  DEPTH     = 16,
    parameter int  AW        = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] waddr,
    input  payload_t      wdata,
    input  logic [AW-1:0] raddr,
    output payload_t      rdata
);

    payload_t mem [DEPTH];

    ////////////////////////////////////////
    // Write port
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    ////////////////////////////////////////
    // Read port
    ////////////////////////////////////////

    // Old data on a same-address collision
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+hw
hw/cnn_pkg.sv
hw/tile_buffer.sv
hw/data_loader.sv
hw/conv_mac.sv
hw/conv_tile_top.sv
bench/conv_tile_chk.sv
bench/conv_tile_tb.sv
